// File: attn_top.f
common/attn_pkg.sv
common/xw_rd_if.sv
common/qkv_rd_if.sv
hw/input/input_buffer.sv
hw/dot_product8.sv
hw/projection/projection_unit.sv
hw/score/score_unit.sv
hw/weighted_sum_unit.sv
hw/attn_top.sv
verif/tb_clock_gen.sv
verif/attn_tb.sv

// File: common/attn_pkg.sv
// matrix sizes, data widths and input phase boundaries
// shared by every attention block
`default_nettype none

package attn_pkg;

    // matrix geometry, DIM is also the lane count of every dot product
    localparam int DIM      = 8;
    localparam int MAX_ROWS = 8;
    localparam int ROW_W    = 4;
    localparam int IDX_W    = 3;

    // data widths
    localparam int IN_W    = 8;
    localparam int QKV_W   = 2 * IN_W + 3;
    localparam int SCORE_W = 39;
    localparam int OUT_W   = 61;

    // input stream: Wq, Wk and Wv arrive back to back
    localparam int PHASE_LEN   = 64;
    localparam int LOAD_CYCLES = 192;
    localparam int CNT_W       = 8;

endpackage

`default_nettype wire

// File: common/qkv_rd_if.sv
// combinational reads of the Q, K and V banks
// used by the score and weighted sum stages
`timescale 1ns/100ps
`default_nettype none

interface qkv_rd_if;
    import attn_pkg::*;

    logic [IDX_W-1:0]        q_idx;
    logic [IDX_W-1:0]        k_idx;
    logic [IDX_W-1:0]        v_idx;
    logic signed [QKV_W-1:0] q_row [DIM];
    logic signed [QKV_W-1:0] k_row [DIM];
    // column v_idx of V, rows at or above T read as zero
    logic signed [QKV_W-1:0] v_col [MAX_ROWS];

    modport proj (input q_idx, input k_idx, input v_idx, output q_row, output k_row, output v_col);
    modport score (output q_idx, output k_idx, input q_row, input k_row);
    modport wsum (output v_idx, input v_col);

endinterface

`default_nettype wire

// File: common/xw_rd_if.sv
// combinational read port from the projection unit into the input buffer
`timescale 1ns/100ps
`default_nettype none

interface xw_rd_if;
    import attn_pkg::*;

    // 0 selects Wq, 1 Wk, 2 Wv
    logic [1:0]             mat_sel;
    logic [IDX_W-1:0]       row_idx;
    logic [IDX_W-1:0]       col_idx;
    logic signed [IN_W-1:0] x_row [DIM];
    logic signed [IN_W-1:0] w_col [DIM];

    modport buffer (input mat_sel, input row_idx, input col_idx, output x_row, output w_col);
    modport proj (output mat_sel, output row_idx, output col_idx, input x_row, input w_col);

endinterface

`default_nettype wire

// File: hw/attn_top.sv
// single-head attention top level
// input buffer, projection, score and weighted sum stages
`timescale 1ns/100ps
`default_nettype none

module attn_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [attn_pkg::ROW_W-1:0]        t_rows,
    input  logic signed [attn_pkg::IN_W-1:0]  x_data,
    input  logic signed [attn_pkg::IN_W-1:0]  wq_data,
    input  logic signed [attn_pkg::IN_W-1:0]  wk_data,
    input  logic signed [attn_pkg::IN_W-1:0]  wv_data,
    output logic                              out_valid,
    output logic signed [attn_pkg::OUT_W-1:0] out_data
);
    import attn_pkg::*;

    logic [ROW_W-1:0]   row_count;
    logic               load_done;
    logic               proj_done;
    logic               score_done;
    logic               out_done;
    logic [IDX_W-1:0]   s_idx;
    logic [SCORE_W-1:0] s_row [MAX_ROWS];

    xw_rd_if  xw ();
    qkv_rd_if qkv ();

    input_buffer u_input (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_rows    (t_rows),
        .x_data    (x_data),
        .wq_data   (wq_data),
        .wk_data   (wk_data),
        .wv_data   (wv_data),
        .out_done  (out_done),
        .load_done (load_done),
        .row_count (row_count),
        .rd        (xw.buffer)
    );

    projection_unit u_proj (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_done (load_done),
        .row_count (row_count),
        .proj_done (proj_done),
        .xw        (xw.proj),
        .qkv       (qkv.proj)
    );

    score_unit u_score (
        .clk        (clk),
        .rst_n      (rst_n),
        .proj_done  (proj_done),
        .row_count  (row_count),
        .s_idx      (s_idx),
        .score_done (score_done),
        .s_row      (s_row),
        .qkv        (qkv.score)
    );

    weighted_sum_unit u_wsum (
        .clk        (clk),
        .rst_n      (rst_n),
        .score_done (score_done),
        .row_count  (row_count),
        .s_row      (s_row),
        .s_idx      (s_idx),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_done   (out_done),
        .qkv        (qkv.wsum)
    );

endmodule

`default_nettype wire

// File: hw/dot_product8.sv
// eight-lane signed multiply and adder tree with a registered sum
`timescale 1ns/100ps
`default_nettype none

module dot_product8 #(
    parameter int A_W = 8,
    parameter int B_W = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic signed [A_W-1:0]    a_vec [attn_pkg::DIM],
    input  logic signed [B_W-1:0]    b_vec [attn_pkg::DIM],
    output logic signed [A_W+B_W+2:0] sum
);
    import attn_pkg::*;

    logic signed [A_W+B_W-1:0] prod [DIM];
    logic signed [A_W+B_W:0]   lvl1 [DIM/2];
    logic signed [A_W+B_W+1:0] lvl2 [DIM/4];
    logic signed [A_W+B_W+2:0] total;

    // each tree level grows by one bit
    always_comb begin
        for (int k = 0; k < DIM; k++) begin
            prod[k] = a_vec[k] * b_vec[k];
        end
        for (int k = 0; k < DIM / 2; k++) begin
            lvl1[k] = prod[2*k] + prod[2*k+1];
        end
        for (int k = 0; k < DIM / 4; k++) begin
            lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
        end
        total = lvl2[0] + lvl2[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else begin
            sum <= total;
        end
    end

endmodule

`default_nettype wire

// File: hw/input/input_buffer.sv
// input beat counter, T register, X and weight storage, busy flag
`timescale 1ns/100ps
`default_nettype none

module input_buffer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [attn_pkg::ROW_W-1:0]         t_rows,
    input  logic signed [attn_pkg::IN_W-1:0]   x_data,
    input  logic signed [attn_pkg::IN_W-1:0]   wq_data,
    input  logic signed [attn_pkg::IN_W-1:0]   wk_data,
    input  logic signed [attn_pkg::IN_W-1:0]   wv_data,
    input  logic                               out_done,
    output logic                               load_done,
    output logic [attn_pkg::ROW_W-1:0]         row_count,
    xw_rd_if.buffer                            rd
);
    import attn_pkg::*;

    logic [CNT_W-1:0]       cnt;
    logic                   busy;
    logic                   accept;
    logic [1:0]             w_sel;
    logic [IDX_W-1:0]       beat_row;
    logic [IDX_W-1:0]       beat_col;
    logic signed [IN_W-1:0] w_in;
    logic [ROW_W-1:0]       t_eff;

    logic signed [IN_W-1:0] x_mem [MAX_ROWS][DIM];
    logic signed [IN_W-1:0] w_mem [LOAD_CYCLES/PHASE_LEN][DIM][DIM];

    // a new run starts only when idle, later beats only while the count runs
    assign accept   = in_valid && (!busy || cnt != '0);
    assign w_sel    = 2'(cnt / PHASE_LEN);
    assign beat_row = IDX_W'((cnt % PHASE_LEN) / DIM);
    assign beat_col = IDX_W'(cnt % DIM);
    assign t_eff    = (t_rows == '0 || t_rows > ROW_W'(MAX_ROWS)) ? ROW_W'(MAX_ROWS) : t_rows;

    always_comb begin
        case (w_sel)
            2'd0:    w_in = wq_data;
            2'd1:    w_in = wk_data;
            default: w_in = wv_data;
        endcase
    end

    // ########################################################################
    // beat counter and run control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            busy      <= 1'b0;
            load_done <= 1'b0;
            row_count <= ROW_W'(MAX_ROWS);
        end else begin
            load_done <= accept && cnt == CNT_W'(LOAD_CYCLES - 1);
            if (accept) begin
                cnt <= (cnt == CNT_W'(LOAD_CYCLES - 1)) ? '0 : cnt + 1'b1;
            end
            if (out_done) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
            if (accept && cnt == '0) begin
                row_count <= t_eff;
            end
        end
    end

    // ########################################################################
    // storage, X rows beyond T are written as zero
    always_ff @(posedge clk) begin
        if (accept) begin
            w_mem[w_sel][beat_row][beat_col] <= w_in;
            if (cnt < DIM * DIM) begin
                x_mem[beat_row][beat_col] <= (ROW_W'(beat_row) < row_count) ? x_data : '0;
            end
        end
    end

    always_comb begin
        rd.x_row = x_mem[rd.row_idx];
        for (int k = 0; k < DIM; k++) begin
            rd.w_col[k] = w_mem[rd.mat_sel][k][rd.col_idx];
        end
    end

endmodule

`default_nettype wire

// File: hw/projection/projection_unit.sv
// Q, K and V projection sequencer and the Q, K and V register banks
`timescale 1ns/100ps
`default_nettype none

module projection_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_done,
    input  logic [attn_pkg::ROW_W-1:0] row_count,
    output logic                       proj_done,
    xw_rd_if.proj                      xw,
    qkv_rd_if.proj                     qkv
);
    import attn_pkg::*;

    logic                    active;
    logic [1:0]              mat;
    logic [IDX_W-1:0]        row;
    logic [IDX_W-1:0]        col;
    logic                    last_row;
    logic                    last_col;
    logic                    last_issue;
    logic                    wr_en;
    logic                    wr_last;
    logic [1:0]              mat_d;
    logic [IDX_W-1:0]        row_d;
    logic [IDX_W-1:0]        col_d;
    logic signed [QKV_W-1:0] prod;

    // bank 0 holds Q, 1 holds K, 2 holds V
    logic signed [QKV_W-1:0] qkv_mem [LOAD_CYCLES/PHASE_LEN][MAX_ROWS][DIM];

    assign xw.mat_sel = mat;
    assign xw.row_idx = row;
    assign xw.col_idx = col;

    assign last_col   = col == IDX_W'(DIM - 1);
    assign last_row   = (ROW_W'(row) + ROW_W'(1)) == row_count;
    assign last_issue = active && last_col && last_row && mat == 2'd2;

    dot_product8 #(
        .A_W (IN_W),
        .B_W (IN_W)
    ) u_dot (
        .clk   (clk),
        .rst_n (rst_n),
        .a_vec (xw.x_row),
        .b_vec (xw.w_col),
        .sum   (prod)
    );

    // ########################################################################
    // walk matrix, then row, then column, one element per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            mat       <= '0;
            row       <= '0;
            col       <= '0;
            wr_en     <= 1'b0;
            wr_last   <= 1'b0;
            proj_done <= 1'b0;
        end else begin
            wr_en     <= active;
            wr_last   <= last_issue;
            proj_done <= wr_en && wr_last;
            if (load_done) begin
                active <= 1'b1;
                mat    <= '0;
                row    <= '0;
                col    <= '0;
            end else if (active) begin
                // col wraps by itself after the last column
                col <= col + 1'b1;
                if (last_col) begin
                    row <= last_row ? '0 : row + 1'b1;
                    if (last_row) begin
                        if (mat == 2'd2) begin
                            active <= 1'b0;
                        end else begin
                            mat <= mat + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // destination index trails the issue by the product latency
    always_ff @(posedge clk) begin
        mat_d <= mat;
        row_d <= row;
        col_d <= col;
        if (wr_en) begin
            qkv_mem[mat_d][row_d][col_d] <= prod;
        end
    end

    always_comb begin
        qkv.q_row = qkv_mem[0][qkv.q_idx];
        qkv.k_row = qkv_mem[1][qkv.k_idx];
        for (int r = 0; r < MAX_ROWS; r++) begin
            qkv.v_col[r] = (ROW_W'(r) < row_count) ? qkv_mem[2][r][qkv.v_idx] : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/score/score_unit.sv
// Q times K transpose sequencer, clamp and divide by three, S register bank
`timescale 1ns/100ps
`default_nettype none

module score_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         proj_done,
    input  logic [attn_pkg::ROW_W-1:0]   row_count,
    input  logic [attn_pkg::IDX_W-1:0]   s_idx,
    output logic                         score_done,
    output logic [attn_pkg::SCORE_W-1:0] s_row [attn_pkg::MAX_ROWS],
    qkv_rd_if.score                      qkv
);
    import attn_pkg::*;

    logic                        active;
    logic [IDX_W-1:0]            i;
    logic [IDX_W-1:0]            j;
    logic                        last_i;
    logic                        last_j;
    logic                        last_issue;
    logic                        wr_en;
    logic                        wr_last;
    logic [IDX_W-1:0]            i_d;
    logic [IDX_W-1:0]            j_d;
    logic signed [2*QKV_W+2:0]   qk;
    logic [2*QKV_W+1:0]          qk_pos;
    logic [SCORE_W-1:0]          score;
    logic [SCORE_W-1:0]          s_mem [MAX_ROWS][MAX_ROWS];

    assign qkv.q_idx = i;
    assign qkv.k_idx = j;

    assign last_i     = (ROW_W'(i) + ROW_W'(1)) == row_count;
    assign last_j     = (ROW_W'(j) + ROW_W'(1)) == row_count;
    assign last_issue = active && last_i && last_j;

    dot_product8 #(
        .A_W (QKV_W),
        .B_W (QKV_W)
    ) u_dot (
        .clk   (clk),
        .rst_n (rst_n),
        .a_vec (qkv.q_row),
        .b_vec (qkv.k_row),
        .sum   (qk)
    );

    // negative scores clamp to zero, the quotient always fits SCORE_W
    assign qk_pos = qk[2*QKV_W+2] ? '0 : qk[2*QKV_W+1:0];
    assign score  = SCORE_W'(qk_pos / 3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            i          <= '0;
            j          <= '0;
            wr_en      <= 1'b0;
            wr_last    <= 1'b0;
            score_done <= 1'b0;
        end else begin
            wr_en      <= active;
            wr_last    <= last_issue;
            score_done <= wr_en && wr_last;
            if (proj_done) begin
                active <= 1'b1;
                i      <= '0;
                j      <= '0;
            end else if (active) begin
                if (last_j) begin
                    j <= '0;
                    if (last_i) begin
                        active <= 1'b0;
                    end else begin
                        i <= i + 1'b1;
                    end
                end else begin
                    j <= j + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        i_d <= i;
        j_d <= j;
        if (wr_en) begin
            s_mem[i_d][j_d] <= score;
        end
    end

    // entries past T hold data of an earlier run and read as zero
    always_comb begin
        for (int k = 0; k < MAX_ROWS; k++) begin
            s_row[k] = (ROW_W'(k) < row_count) ? s_mem[s_idx][k] : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/weighted_sum_unit.sv
// S times V sequencer and the output stream
`timescale 1ns/100ps
`default_nettype none

module weighted_sum_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              score_done,
    input  logic [attn_pkg::ROW_W-1:0]        row_count,
    input  logic [attn_pkg::SCORE_W-1:0]      s_row [attn_pkg::MAX_ROWS],
    output logic [attn_pkg::IDX_W-1:0]        s_idx,
    output logic                              out_valid,
    output logic signed [attn_pkg::OUT_W-1:0] out_data,
    output logic                              out_done,
    qkv_rd_if.wsum                            qkv
);
    import attn_pkg::*;

    logic                              active;
    logic [IDX_W-1:0]                  row;
    logic [IDX_W-1:0]                  col;
    logic                              last_row;
    logic                              last_col;
    logic                              last_issue;
    logic signed [SCORE_W:0]           s_vec [DIM];
    logic signed [SCORE_W+QKV_W+3:0]   prod;

    assign s_idx     = row;
    assign qkv.v_idx = col;

    assign last_col   = col == IDX_W'(DIM - 1);
    assign last_row   = (ROW_W'(row) + ROW_W'(1)) == row_count;
    assign last_issue = active && last_col && last_row;

    // scores are unsigned, a zero sign bit makes them positive lanes
    always_comb begin
        for (int k = 0; k < DIM; k++) begin
            s_vec[k] = {1'b0, s_row[k]};
        end
    end

    dot_product8 #(
        .A_W (SCORE_W + 1),
        .B_W (QKV_W)
    ) u_dot (
        .clk   (clk),
        .rst_n (rst_n),
        .a_vec (s_vec),
        .b_vec (qkv.v_col),
        .sum   (prod)
    );

    // the product register is the output register, top bit is only sign
    assign out_data = prod[OUT_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            row       <= '0;
            col       <= '0;
            out_valid <= 1'b0;
            out_done  <= 1'b0;
        end else begin
            out_valid <= active;
            out_done  <= last_issue;
            if (score_done) begin
                active <= 1'b1;
                row    <= '0;
                col    <= '0;
            end else if (active) begin
                col <= col + 1'b1;
                if (last_col) begin
                    row <= last_row ? '0 : row + 1'b1;
                    if (last_row) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/attn_tb.sv
// attention testbench top level
// stimulus, reference model, output monitor with compares, timeout
`timescale 1ns/100ps
`default_nettype none

module attn_tb;
    import attn_pkg::*;

    localparam int SEED        = 65;
    localparam int BEAT_W      = ROW_W + IDX_W;
    localparam int IDLE_CYCLES = 4;
    localparam int GAP_CYCLES  = 6;
    // eight runs, each load, compute and burst well inside 600 cycles, plus margin
    localparam int NUM_RUNS       = 8;
    localparam int RUN_LIMIT      = 600;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_LIMIT + 1200;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic [ROW_W-1:0]          t_rows;
    logic signed [IN_W-1:0]    x_data;
    logic signed [IN_W-1:0]    wq_data;
    logic signed [IN_W-1:0]    wk_data;
    logic signed [IN_W-1:0]    wv_data;
    logic                      out_valid;
    logic signed [OUT_W-1:0]   out_data;

    // applied matrices, w_m index 0 is Wq, 1 Wk, 2 Wv
    logic signed [IN_W-1:0]  x_m [MAX_ROWS][DIM];
    logic signed [IN_W-1:0]  w_m [3][DIM][DIM];
    logic signed [OUT_W-1:0] exp_o [MAX_ROWS*DIM];
    logic [BEAT_W-1:0]       exp_len;
    logic [BEAT_W-1:0]       beat_cnt;
    logic                    armed;
    logic                    in_burst;
    logic                    burst_done;
    int                      cycle_cnt;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (5)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    attn_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_rows    (t_rows),
        .x_data    (x_data),
        .wq_data   (wq_data),
        .wk_data   (wk_data),
        .wv_data   (wv_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // ########################################################################
    // reference model

    function automatic int eff_rows(input int t);
        return (t == 0 || t > MAX_ROWS) ? MAX_ROWS : t;
    endfunction

    // element (i, c) of X times weight matrix m
    function automatic longint proj_elem(input int m, input int i, input int c);
        longint acc;
        acc = 0;
        for (int k = 0; k < DIM; k++) begin
            acc += longint'(x_m[i][k]) * longint'(w_m[m][k][c]);
        end
        return acc;
    endfunction

    // Q row i dot K row j, negative clamps to zero, then floor of a third
    function automatic longint score_elem(input int i, input int j);
        longint acc;
        acc = 0;
        for (int k = 0; k < DIM; k++) begin
            acc += proj_elem(0, i, k) * proj_elem(1, j, k);
        end
        if (acc < 0) begin
            acc = 0;
        end
        return acc / 3;
    endfunction

    function automatic longint ref_out(input int t, input int i, input int c);
        longint acc;
        acc = 0;
        for (int j = 0; j < t; j++) begin
            acc += score_elem(i, j) * proj_elem(2, j, c);
        end
        return acc;
    endfunction

    // ########################################################################
    // compares and failure exit

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_out(input logic signed [OUT_W-1:0] got,
                             input logic signed [OUT_W-1:0] exp, input int beat);
        if (got !== exp) begin
            $display("FAIL out_data beat %0d: expected %h, got %h", beat, exp, got);
            abort_run();
        end
    endtask

    task automatic check_count(input logic [BEAT_W-1:0] got, input logic [BEAT_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL out_valid beat count: expected %h, got %h", exp, got);
            abort_run();
        end
    endtask

    // ########################################################################
    // stimulus

    function automatic logic signed [IN_W-1:0] rand_byte();
        return IN_W'($urandom);
    endfunction

    // with neg_k set, Wk = -Wq so every row scores negative against itself
    task automatic fill_matrices(input bit neg_k);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                x_m[r][c] = rand_byte();
                for (int m = 0; m < 3; m++) begin
                    w_m[m][r][c] = rand_byte();
                end
                if (neg_k) begin
                    if (w_m[0][r][c] == -128) begin
                        w_m[0][r][c] = -127;
                    end
                    w_m[1][r][c] = -w_m[0][r][c];
                end
            end
        end
    endtask

    task automatic start_run(input int t);
        int eff;
        eff = eff_rows(t);
        for (int i = 0; i < eff; i++) begin
            for (int c = 0; c < DIM; c++) begin
                exp_o[i*DIM + c] = OUT_W'(ref_out(eff, i, c));
            end
        end
        exp_len    = BEAT_W'(eff * DIM);
        beat_cnt   = '0;
        burst_done = 1'b0;
        armed      = 1'b1;
    endtask

    // t_rows only counts on the first beat, later beats carry noise
    task automatic drive_load(input int t);
        int r;
        int c;
        for (int cyc = 0; cyc < LOAD_CYCLES; cyc++) begin
            @(negedge clk);
            r        = (cyc % PHASE_LEN) / DIM;
            c        = cyc % DIM;
            in_valid = 1'b1;
            t_rows   = (cyc == 0) ? ROW_W'(t) : ROW_W'($urandom);
            x_data   = (cyc < DIM * DIM) ? x_m[r][c] : rand_byte();
            wq_data  = w_m[0][r][c];
            wk_data  = w_m[1][r][c];
            wv_data  = w_m[2][r][c];
        end
    endtask

    // noise drives random in_valid pulses while the DUT is still busy
    // gives up when no burst starts within one run length
    task automatic await_burst(input bit noise);
        bit seen;
        bit finished;
        int waited;
        seen     = 1'b0;
        finished = 1'b0;
        waited   = 0;
        while (!finished) begin
            @(negedge clk);
            waited++;
            if (out_valid) begin
                seen = 1'b1;
            end
            if ((seen && !out_valid) || (!seen && waited >= RUN_LIMIT)) begin
                finished = 1'b1;
            end
            if (noise && !finished) begin
                in_valid = 1'($urandom);
                t_rows   = ROW_W'($urandom);
                x_data   = rand_byte();
                wq_data  = rand_byte();
                wk_data  = rand_byte();
                wv_data  = rand_byte();
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic run_case(input int t, input bit neg_k, input bit noise);
        fill_matrices(neg_k);
        start_run(t);
        drive_load(t);
        await_burst(noise);
        repeat (GAP_CYCLES) @(negedge clk);
        if (!burst_done) begin
            $display("no complete output burst was seen for T=%0d", t);
            abort_run();
        end
    endtask

    // ########################################################################
    // output monitor, sampled on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (!armed) begin
                $display("out_valid went high while no run was in progress");
                abort_run();
            end else if (beat_cnt < exp_len) begin
                check_out(out_data, exp_o[beat_cnt], int'(beat_cnt));
                beat_cnt = beat_cnt + 1'b1;
                in_burst = 1'b1;
            end else begin
                $display("output burst ran past the expected %0d beats", exp_len);
                abort_run();
            end
        end else if (in_burst) begin
            check_count(beat_cnt, exp_len);
            in_burst   = 1'b0;
            armed      = 1'b0;
            burst_done = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT did not finish its runs", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        in_valid    = 1'b0;
        t_rows      = '0;
        x_data      = '0;
        wq_data     = '0;
        wk_data     = '0;
        wv_data     = '0;
        exp_len     = '0;
        beat_cnt    = '0;
        armed       = 1'b0;
        in_burst    = 1'b0;
        burst_done  = 1'b0;
        cycle_cnt   = 0;

        @(posedge rst_n);
        repeat (IDLE_CYCLES) @(negedge clk);

        run_case(8, 1'b0, 1'b0);
        run_case(1, 1'b0, 1'b0);
        run_case(4, 1'b0, 1'b0);
        // self scores clamp, T=1 gives an all-zero burst
        run_case(8, 1'b1, 1'b0);
        run_case(1, 1'b1, 1'b0);
        run_case(6, 1'b0, 1'b1);
        // out of range T behaves as 8
        run_case(0, 1'b0, 1'b0);
        run_case(12, 1'b0, 1'b0);

        repeat (IDLE_CYCLES) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
